/* tracker_macros.svh */
`ifndef TRACKER_MACROS_SVH
`define TRACKER_MACROS_SVH

// visible and total columns of the test raster
`define H_ACTIVE 64
`define H_TOTAL 80

// visible and total rows
`define V_ACTIVE 48
`define V_TOTAL 52

// coordinate widths, sized to hold the totals
`define H_BITS 7
`define V_BITS 6

// coordinate sums over one frame of mask pixels
// worst case 79 * 64 * 48 stays well below 2^24
`define SUM_BITS 24

// mask pixel count, up to 64 * 48 = 3072
`define CNT_BITS 12

`endif

/* video_pkg.sv */
`default_nettype none

`include "tracker_macros.svh"

package video_pkg;

  // raster coordinates
  typedef logic [`H_BITS-1:0] hcount_t;
  typedef logic [`V_BITS-1:0] vcount_t;

  // one 8-bit colour channel or derived value
  typedef logic [7:0] chan_t;

  // 24-bit pixel, red in the top byte
  typedef struct packed {
    chan_t red;
    chan_t green;
    chan_t blue;
  } pixel_t;

  // which channel feeds the threshold
  typedef enum logic [1:0] {
    CH_RED   = 2'd0,
    CH_GREEN = 2'd1,
    CH_BLUE  = 2'd2,
    CH_LUMA  = 2'd3
  } channel_sel_e;

  // what the output pixel shows
  typedef enum logic [1:0] {
    DISP_CAMERA    = 2'd0,
    DISP_CHANNEL   = 2'd1,
    DISP_MASK      = 2'd2,
    DISP_MASK_OVER = 2'd3
  } display_mode_e;

endpackage

`default_nettype wire

/* com_pkg.sv */
`default_nettype none

`include "tracker_macros.svh"

package com_pkg;

  // per-frame coordinate sums and mask pixel count
  typedef logic [`SUM_BITS-1:0] xsum_t;
  typedef logic [`SUM_BITS-1:0] ysum_t;
  typedef logic [`CNT_BITS-1:0] count_t;

  // divider sequence, x axis first then y
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_X    = 2'd1,
    DIV_Y    = 2'd2,
    DIV_DONE = 2'd3
  } div_state_e;

endpackage

`default_nettype wire

/* tracker_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// raster position and flags; the delayed copy also carries the mask bit
interface raster_if import video_pkg::*; ();
  hcount_t hcount;
  vcount_t vcount;
  logic    active;
  logic    new_frame;
  logic    mask;

  // timing generator side
  modport gen (output hcount, vcount, active, new_frame, mask);
  // consumers of either copy
  modport sink (input hcount, vcount, active, new_frame, mask);
  // registered copy, one cycle behind the generator
  modport delayed (output hcount, vcount, active, new_frame, mask);
endinterface

// finished frame totals handed from accumulator to divider
interface com_sum_if import com_pkg::*; ();
  xsum_t  x_sum;
  ysum_t  y_sum;
  count_t count;
  // one-cycle strobe, totals valid with it
  logic   tabulate;

  modport src (output x_sum, y_sum, count, tabulate);
  modport dst (input x_sum, y_sum, count, tabulate);
endinterface

`default_nettype wire

/* video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tracker_macros.svh"

module video_timing import video_pkg::*; (
  input wire     clk_pixel,
  input wire     recent_reset,
  raster_if.gen  raster
);

  hcount_t h_cnt;
  vcount_t v_cnt;
  hcount_t h_next;
  vcount_t v_next;
  logic    h_last;
  logic    v_last;
  logic    new_frame_q;

  // next position, column wraps first and then bumps the row
  always_comb begin
    h_last = (h_cnt == hcount_t'(`H_TOTAL - 1));
    v_last = (v_cnt == vcount_t'(`V_TOTAL - 1));
    h_next = h_last ? '0 : h_cnt + 1'b1;
    if (h_last) begin
      v_next = v_last ? '0 : v_cnt + 1'b1;
    end else begin
      v_next = v_cnt;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      h_cnt       <= '0;
      v_cnt       <= '0;
      new_frame_q <= 1'b0;
    end else begin
      h_cnt       <= h_next;
      v_cnt       <= v_next;
      // flag lands together with the 0,0 position
      new_frame_q <= (h_next == '0) && (v_next == '0);
    end
  end

  assign raster.hcount    = h_cnt;
  assign raster.vcount    = v_cnt;
  assign raster.new_frame = new_frame_q;
  // visible area is the top-left corner of the raster
  assign raster.active    = (h_cnt < hcount_t'(`H_ACTIVE)) &&
                            (v_cnt < vcount_t'(`V_ACTIVE));
  // the raw raster has no threshold result yet
  assign raster.mask      = 1'b0;

endmodule

`default_nettype wire

/* channel_mask.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_mask import video_pkg::*; (
  input wire            clk_pixel,
  input wire            recent_reset,
  raster_if.sink        raster,
  input pixel_t         pixel_i,
  input channel_sel_e   channel_sel_i,
  input chan_t          lower_i,
  input chan_t          upper_i,
  raster_if.delayed     out,
  output chan_t         channel_o,
  output pixel_t        pixel_d_o
);

  logic [9:0] luma_sum;
  chan_t      luma;
  chan_t      value;
  logic       mask_c;

  // cheap luma: (r + 2g + b) / 4, truncated
  assign luma_sum = {2'b00, pixel_i.red} + {1'b0, pixel_i.green, 1'b0} +
                    {2'b00, pixel_i.blue};
  assign luma     = luma_sum[9:2];

  always_comb begin
    case (channel_sel_i)
      CH_RED:   value = pixel_i.red;
      CH_GREEN: value = pixel_i.green;
      CH_BLUE:  value = pixel_i.blue;
      default:  value = luma;
    endcase
  end

  // inclusive window, blanking never counts
  assign mask_c = raster.active && (value >= lower_i) && (value <= upper_i);

  // flags
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      out.active    <= 1'b0;
      out.new_frame <= 1'b0;
      out.mask      <= 1'b0;
    end else begin
      out.active    <= raster.active;
      out.new_frame <= raster.new_frame;
      out.mask      <= mask_c;
    end
  end

  // coordinates and pixel data follow the flags by the same one cycle
  always_ff @(posedge clk_pixel) begin
    out.hcount <= raster.hcount;
    out.vcount <= raster.vcount;
    channel_o  <= value;
    pixel_d_o  <= pixel_i;
  end

endmodule

`default_nettype wire

/* com_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module com_accumulator import com_pkg::*; (
  input wire      clk_pixel,
  input wire      recent_reset,
  raster_if.sink  in,
  com_sum_if.src  sums
);

  xsum_t  acc_x;
  ysum_t  acc_y;
  count_t acc_n;
  logic   hit;

  // masked pixel in the visible area
  assign hit = in.active && in.mask;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      acc_x         <= '0;
      acc_y         <= '0;
      acc_n         <= '0;
      sums.tabulate <= 1'b0;
    end else if (in.new_frame) begin
      // hand over last frame and restart with the current pixel
      sums.tabulate <= 1'b1;
      acc_x         <= hit ? xsum_t'(in.hcount) : '0;
      acc_y         <= hit ? ysum_t'(in.vcount) : '0;
      acc_n         <= hit ? count_t'(1) : '0;
    end else begin
      sums.tabulate <= 1'b0;
      if (hit) begin
        acc_x <= acc_x + xsum_t'(in.hcount);
        acc_y <= acc_y + ysum_t'(in.vcount);
        acc_n <= acc_n + 1'b1;
      end
    end
  end

  // totals only matter alongside tabulate
  always_ff @(posedge clk_pixel) begin
    if (in.new_frame) begin
      sums.x_sum <= acc_x;
      sums.y_sum <= acc_y;
      sums.count <= acc_n;
    end
  end

endmodule

`default_nettype wire

/* com_divider.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tracker_macros.svh"

module com_divider import video_pkg::*, com_pkg::*; (
  input wire      clk_pixel,
  input wire      recent_reset,
  com_sum_if.dst  sums,
  output hcount_t com_x_o,
  output vcount_t com_y_o,
  output logic    com_valid_o
);

  localparam int STEP_BITS = $clog2(`SUM_BITS);

  div_state_e           state;
  logic [STEP_BITS-1:0] step;
  logic                 last_step;
  // dividend shifts out the top while quotient bits shift in below
  xsum_t                div_q;
  ysum_t                y_hold;
  count_t               divisor;
  count_t               rem;
  hcount_t              x_quot;
  logic [`CNT_BITS:0]   rem_shift;
  logic [`CNT_BITS:0]   rem_diff;
  logic                 fits;
  xsum_t                q_next;
  count_t               rem_next;

  // one restoring step per cycle
  always_comb begin
    rem_shift = {rem, div_q[`SUM_BITS-1]};
    rem_diff  = rem_shift - {1'b0, divisor};
    fits      = (rem_shift >= {1'b0, divisor});
    q_next    = {div_q[`SUM_BITS-2:0], fits};
    // remainder stays below the divisor, so the top bit drops cleanly
    rem_next  = fits ? rem_diff[`CNT_BITS-1:0] : rem_shift[`CNT_BITS-1:0];
  end

  assign last_step = (step == STEP_BITS'(`SUM_BITS - 1));

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      state   <= DIV_IDLE;
      com_x_o <= '0;
      com_y_o <= '0;
    end else begin
      case (state)
        DIV_IDLE: begin
          // empty frames leave the last centre in place
          if (sums.tabulate && (sums.count != '0)) begin
            state <= DIV_X;
          end
        end
        DIV_X: begin
          if (last_step) begin
            state <= DIV_Y;
          end
        end
        DIV_Y: begin
          if (last_step) begin
            // both axes update together
            com_x_o <= x_quot;
            com_y_o <= q_next[`V_BITS-1:0];
            state   <= DIV_DONE;
          end
        end
        default: begin
          state <= DIV_IDLE;
        end
      endcase
    end
  end

  // datapath, sequenced by the state above
  always_ff @(posedge clk_pixel) begin
    case (state)
      DIV_IDLE: begin
        div_q   <= sums.x_sum;
        y_hold  <= sums.y_sum;
        divisor <= sums.count;
        rem     <= '0;
        step    <= '0;
      end
      DIV_X: begin
        if (last_step) begin
          // centre lies in the raster, low bits hold the whole quotient
          x_quot <= q_next[`H_BITS-1:0];
          div_q  <= xsum_t'(y_hold);
          rem    <= '0;
          step   <= '0;
        end else begin
          div_q <= q_next;
          rem   <= rem_next;
          step  <= step + 1'b1;
        end
      end
      DIV_Y: begin
        div_q <= q_next;
        rem   <= rem_next;
        step  <= step + 1'b1;
      end
      default: begin
        step <= '0;
      end
    endcase
  end

  // one-cycle pulse, centre already updated
  assign com_valid_o = (state == DIV_DONE);

endmodule

`default_nettype wire

/* overlay_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module overlay_mux import video_pkg::*; (
  input wire            clk_pixel,
  input wire            recent_reset,
  raster_if.sink        in,
  input pixel_t         pixel_d_i,
  input chan_t          channel_i,
  input display_mode_e  mode_i,
  input wire            crosshair_en_i,
  input hcount_t        com_x_i,
  input vcount_t        com_y_i,
  output pixel_t        pixel_o
);

  localparam pixel_t WHITE   = '{8'hFF, 8'hFF, 8'hFF};
  localparam pixel_t BLACK   = '{8'h00, 8'h00, 8'h00};
  localparam pixel_t MAGENTA = '{8'hFF, 8'h00, 8'hFF};

  pixel_t base;
  pixel_t shown;
  logic   on_cross;

  always_comb begin
    case (mode_i)
      DISP_CAMERA:  base = pixel_d_i;
      // grey from the selected channel
      DISP_CHANNEL: base = '{channel_i, channel_i, channel_i};
      DISP_MASK:    base = in.mask ? WHITE : BLACK;
      default:      base = in.mask ? MAGENTA : pixel_d_i;
    endcase
  end

  // lines through the last reported centre
  assign on_cross = crosshair_en_i &&
                    ((in.hcount == com_x_i) || (in.vcount == com_y_i));

  always_comb begin
    if (!in.active) begin
      shown = BLACK;
    end else if (on_cross) begin
      shown = WHITE;
    end else begin
      shown = base;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      pixel_o <= BLACK;
    end else begin
      pixel_o <= shown;
    end
  end

endmodule

`default_nettype wire

/* color_tracker_top.sv */
`timescale 1ns/1ps
`default_nettype none

module color_tracker_top import video_pkg::*; (
  input wire            clk_pixel,
  input wire            recent_reset,
  // pixel for the coordinates on hcount_o/vcount_o, same cycle
  input pixel_t         pixel_i,
  input channel_sel_e   channel_sel_i,
  input chan_t          lower_i,
  input chan_t          upper_i,
  input display_mode_e  mode_i,
  input wire            crosshair_en_i,
  output hcount_t       hcount_o,
  output vcount_t       vcount_o,
  // two cycles behind the coordinates
  output pixel_t        pixel_o,
  output hcount_t       com_x_o,
  output vcount_t       com_y_o,
  output logic          com_valid_o
);

  // raw raster and its one-cycle-delayed copy with the mask
  raster_if  raster_raw ();
  raster_if  raster_dly ();
  com_sum_if frame_sums ();

  chan_t  channel;
  pixel_t pixel_d;

  video_timing timing_i (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .raster       (raster_raw.gen)
  );

  assign hcount_o = raster_raw.hcount;
  assign vcount_o = raster_raw.vcount;

  channel_mask mask_i (
    .clk_pixel     (clk_pixel),
    .recent_reset  (recent_reset),
    .raster        (raster_raw.sink),
    .pixel_i       (pixel_i),
    .channel_sel_i (channel_sel_i),
    .lower_i       (lower_i),
    .upper_i       (upper_i),
    .out           (raster_dly.delayed),
    .channel_o     (channel),
    .pixel_d_o     (pixel_d)
  );

  com_accumulator accum_i (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .in           (raster_dly.sink),
    .sums         (frame_sums.src)
  );

  com_divider divider_i (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .sums         (frame_sums.dst),
    .com_x_o      (com_x_o),
    .com_y_o      (com_y_o),
    .com_valid_o  (com_valid_o)
  );

  // crosshair follows the held centre
  overlay_mux overlay_i (
    .clk_pixel      (clk_pixel),
    .recent_reset   (recent_reset),
    .in             (raster_dly.sink),
    .pixel_d_i      (pixel_d),
    .channel_i      (channel),
    .mode_i         (mode_i),
    .crosshair_en_i (crosshair_en_i),
    .com_x_i        (com_x_o),
    .com_y_i        (com_y_o),
    .pixel_o        (pixel_o)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  // 4 ns pixel clock, first rising edge at 2 ns
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset seen by three rising edges, dropped just after the third
  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

/* tb_color_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tracker_macros.svh"

module tb_color_tracker import video_pkg::*; ();

  localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
  localparam int NUM_ROWS     = 6;
  // four frames per row at 4 ns a pixel, two more for reset and slack
  localparam int WATCHDOG_NS  = (NUM_ROWS * 4 + 2) * FRAME_CYCLES * 4;

  localparam pixel_t BLACK   = 24'h000000;
  localparam pixel_t WHITE   = 24'hFFFFFF;
  localparam pixel_t MAGENTA = 24'hFF00FF;

  // settings, scene rectangle and the centre the row should give
  typedef struct packed {
    channel_sel_e  sel;
    chan_t         lower;
    chan_t         upper;
    display_mode_e mode;
    logic          xhair;
    int            x0;
    int            x1;
    int            y0;
    int            y1;
    pixel_t        fg;
    pixel_t        bg;
    logic          rand_bg;
    logic          exp_valid;
    int            exp_x;
    int            exp_y;
  } row_t;

  logic          clk_pixel;
  logic          recent_reset;
  pixel_t        pixel_i;
  channel_sel_e  channel_sel_i;
  chan_t         lower_i;
  chan_t         upper_i;
  display_mode_e mode_i;
  logic          crosshair_en_i;
  hcount_t       hcount_o;
  vcount_t       vcount_o;
  pixel_t        pixel_o;
  hcount_t       com_x_o;
  vcount_t       com_y_o;
  logic          com_valid_o;

  row_t        rows [NUM_ROWS];
  logic [31:0] lfsr_state;
  int          cur;
  int          last_cx;
  int          last_cy;
  // coordinates of the last three cycles, index 2 is the oldest
  int          past_h [3];
  int          past_v [3];
  int          checks;
  int          errors;
  int          tests_run;
  int          tests_failed;

  tb_clock_gen clock_i (
    .clk_o   (clk_pixel),
    .reset_o (recent_reset)
  );

  color_tracker_top dut_i (
    .clk_pixel      (clk_pixel),
    .recent_reset   (recent_reset),
    .pixel_i        (pixel_i),
    .channel_sel_i  (channel_sel_i),
    .lower_i        (lower_i),
    .upper_i        (upper_i),
    .mode_i         (mode_i),
    .crosshair_en_i (crosshair_en_i),
    .hcount_o       (hcount_o),
    .vcount_o       (vcount_o),
    .pixel_o        (pixel_o),
    .com_x_o        (com_x_o),
    .com_y_o        (com_y_o),
    .com_valid_o    (com_valid_o)
  );

  // right-shifting galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic is_active(input int h, input int v);
    return (h < `H_ACTIVE) && (v < `V_ACTIVE);
  endfunction

  // rectangle of fg on a bg field
  function automatic pixel_t scene_pixel(input int r, input int h, input int v);
    if (h >= rows[r].x0 && h <= rows[r].x1 &&
        v >= rows[r].y0 && v <= rows[r].y1) begin
      return rows[r].fg;
    end
    return rows[r].bg;
  endfunction

  function automatic chan_t channel_of(input channel_sel_e sel, input pixel_t p);
    int luma;
    luma = (int'(p.red) + 2 * int'(p.green) + int'(p.blue)) / 4;
    case (sel)
      CH_RED:   return p.red;
      CH_GREEN: return p.green;
      CH_BLUE:  return p.blue;
      default:  return chan_t'(luma);
    endcase
  endfunction

  // inclusive window on both ends, visible area only
  function automatic logic is_masked(input int r, input int h, input int v);
    chan_t c;
    c = channel_of(rows[r].sel, scene_pixel(r, h, v));
    return is_active(h, v) && (c >= rows[r].lower) && (c <= rows[r].upper);
  endfunction

  function automatic pixel_t expect_pixel(input int r, input int h, input int v);
    pixel_t p;
    logic   m;
    chan_t  c;
    p = scene_pixel(r, h, v);
    m = is_masked(r, h, v);
    c = channel_of(rows[r].sel, p);
    if (!is_active(h, v)) begin
      return BLACK;
    end
    // crosshair sits on the centre reported before this frame
    if (rows[r].xhair && (h == last_cx || v == last_cy)) begin
      return WHITE;
    end
    case (rows[r].mode)
      DISP_CAMERA:  return p;
      DISP_CHANNEL: return {c, c, c};
      DISP_MASK:    return m ? WHITE : BLACK;
      default:      return m ? MAGENTA : p;
    endcase
  endfunction

  // floor of the mean mask coordinate, no result for an empty mask
  task automatic compute_centre(input int r);
    int sx;
    int sy;
    int n;
    sx = 0;
    sy = 0;
    n  = 0;
    for (int v = 0; v < `V_ACTIVE; v++) begin
      for (int h = 0; h < `H_ACTIVE; h++) begin
        if (is_masked(r, h, v)) begin
          sx += h;
          sy += v;
          n++;
        end
      end
    end
    rows[r].exp_valid = (n != 0);
    rows[r].exp_x     = (n != 0) ? sx / n : 0;
    rows[r].exp_y     = (n != 0) ? sy / n : 0;
  endtask

  task automatic load_table();
    logic [31:0] bits;
    // red block on green, red window around the block
    rows[0] = '{sel: CH_RED, lower: 8'hC0, upper: 8'hFF, mode: DISP_CAMERA,
                xhair: 1'b0, x0: 10, x1: 29, y0: 8, y1: 23, fg: 24'hE02010,
                bg: 24'h10C010, rand_bg: 1'b0, exp_valid: 1'b0, exp_x: 0, exp_y: 0};
    // luma truncates to 0x50, right on the lower bound
    rows[1] = '{sel: CH_LUMA, lower: 8'h50, upper: 8'h70, mode: DISP_CHANNEL,
                xhair: 1'b0, x0: 40, x1: 55, y0: 20, y1: 39, fg: 24'h535050,
                bg: 24'h0, rand_bg: 1'b1, exp_valid: 1'b0, exp_x: 0, exp_y: 0};
    // one-value blue window, strip along the top edge
    rows[2] = '{sel: CH_BLUE, lower: 8'h30, upper: 8'h30, mode: DISP_MASK,
                xhair: 1'b0, x0: 0, x1: 63, y0: 0, y1: 3, fg: 24'h000030,
                bg: 24'h0, rand_bg: 1'b1, exp_valid: 1'b0, exp_x: 0, exp_y: 0};
    // empty window, lower above upper
    rows[3] = '{sel: CH_RED, lower: 8'h80, upper: 8'h7F, mode: DISP_MASK_OVER,
                xhair: 1'b1, x0: 20, x1: 40, y0: 10, y1: 30, fg: 24'hFF0000,
                bg: 24'h0, rand_bg: 1'b1, exp_valid: 1'b0, exp_x: 0, exp_y: 0};
    rows[4] = '{sel: CH_GREEN, lower: 8'hA0, upper: 8'hB0, mode: DISP_MASK_OVER,
                xhair: 1'b1, x0: 50, x1: 63, y0: 30, y1: 47, fg: 24'h20A820,
                bg: 24'h0, rand_bg: 1'b1, exp_valid: 1'b0, exp_x: 0, exp_y: 0};
    // full window, every visible pixel counts
    rows[5] = '{sel: CH_LUMA, lower: 8'h00, upper: 8'hFF, mode: DISP_CAMERA,
                xhair: 1'b1, x0: 5, x1: 15, y0: 5, y1: 15, fg: 24'h808080,
                bg: 24'h0, rand_bg: 1'b1, exp_valid: 1'b0, exp_x: 0, exp_y: 0};
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].rand_bg) begin
        take_bits(24, bits);
        rows[r].bg = bits[23:0];
      end
      compute_centre(r);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // one pixel clock, then drive the pixel for the new coordinates
  task automatic step_cycle();
    @(posedge clk_pixel);
    #1;
    past_h[2] = past_h[1];
    past_h[1] = past_h[0];
    past_h[0] = int'(hcount_o);
    past_v[2] = past_v[1];
    past_v[1] = past_v[0];
    past_v[0] = int'(vcount_o);
    pixel_i = scene_pixel(cur, past_h[0], past_v[0]);
  endtask

  function automatic logic at_frame_start();
    return (hcount_o == '0) && (vcount_o == '0);
  endfunction

  task automatic wait_frame_start();
    do begin
      step_cycle();
    end while (!at_frame_start());
  endtask

  task automatic apply_row(input int r);
    cur            = r;
    channel_sel_i  = rows[r].sel;
    lower_i        = rows[r].lower;
    upper_i        = rows[r].upper;
    mode_i         = rows[r].mode;
    crosshair_en_i = rows[r].xhair;
    pixel_i        = scene_pixel(r, int'(hcount_o), int'(vcount_o));
  endtask

  task automatic wait_valid(output logic found);
    int n;
    found = 1'b0;
    n     = 0;
    while (!found && n < FRAME_CYCLES) begin
      step_cycle();
      found = com_valid_o;
      n++;
    end
    if (!found) begin
      errors++;
      $display("t=%0t: no com_valid_o pulse within one frame for row %0d", $time, cur);
    end
  endtask

  // pixel_o belongs to the coordinates of two cycles back
  task automatic check_frame();
    pixel_t exp;
    int     nh;
    int     nv;
    repeat (FRAME_CYCLES) begin
      step_cycle();
      // raster moves one column a cycle, wrapping at the totals
      nh = (past_h[1] == `H_TOTAL - 1) ? 0 : past_h[1] + 1;
      nv = past_v[1];
      if (past_h[1] == `H_TOTAL - 1) begin
        nv = (past_v[1] == `V_TOTAL - 1) ? 0 : past_v[1] + 1;
      end
      check_value("hcount_o", 32'(hcount_o), nh);
      check_value("vcount_o", 32'(vcount_o), nv);
      exp = expect_pixel(cur, past_h[2], past_v[2]);
      check_value($sformatf("pixel_o at %0d,%0d", past_h[2], past_v[2]),
                  32'(pixel_o), 32'(exp));
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("%s: %0d mismatches", name, errors - err_before);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  initial begin : main_seq
    int   err_before;
    int   pulses;
    logic found;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    lfsr_state   = 32'h1f77af64;
    load_table();
    cur     = 0;
    last_cx = 0;
    last_cy = 0;
    for (int i = 0; i < 3; i++) begin
      past_h[i] = `H_TOTAL - 1;
      past_v[i] = `V_TOTAL - 1;
    end
    // nothing passes this window, so the mask view stays black
    pixel_i        = scene_pixel(0, 0, 0);
    channel_sel_i  = CH_RED;
    lower_i        = 8'hFF;
    upper_i        = 8'h00;
    mode_i         = DISP_MASK;
    crosshair_en_i = 1'b0;

    // reset, then the first frame up to the wrap
    err_before = errors;
    repeat (3) begin
      step_cycle();
      check_value("hcount_o", 32'(hcount_o), 32'd0);
      check_value("vcount_o", 32'(vcount_o), 32'd0);
      check_value("com_valid_o", 32'(com_valid_o), 32'd0);
      check_value("com_x_o", 32'(com_x_o), 32'd0);
      check_value("com_y_o", 32'(com_y_o), 32'd0);
      check_value("pixel_o", 32'(pixel_o), 32'(BLACK));
    end
    step_cycle();
    while (!at_frame_start()) begin
      check_value("com_valid_o", 32'(com_valid_o), 32'd0);
      check_value("pixel_o", 32'(pixel_o), 32'(BLACK));
      step_cycle();
    end
    finish_test("reset and first frame", err_before);

    // each row: one frame measured, result during the next, then a frame of pixels
    for (int r = 0; r < NUM_ROWS; r++) begin
      err_before = errors;
      apply_row(r);
      wait_frame_start();
      if (rows[r].exp_valid) begin
        wait_valid(found);
        if (found) begin
          check_value("com_x_o", 32'(com_x_o), rows[r].exp_x);
          check_value("com_y_o", 32'(com_y_o), rows[r].exp_y);
        end
        last_cx = rows[r].exp_x;
        last_cy = rows[r].exp_y;
        wait_frame_start();
      end else begin
        // empty frame, no pulse and the old centre stays
        pulses = 0;
        do begin
          step_cycle();
          if (com_valid_o) begin
            pulses++;
          end
        end while (!at_frame_start());
        check_value("com_valid_o pulses", pulses, 32'd0);
        check_value("com_x_o", 32'(com_x_o), last_cx);
        check_value("com_y_o", 32'(com_y_o), last_cy);
      end
      check_frame();
      finish_test($sformatf("row %0d, centre %0d,%0d", r, last_cx, last_cy), err_before);
    end

    $display("tests %0d, failed tests %0d, checks %0d, mismatches %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
video_pkg.sv
com_pkg.sv
tracker_ifs.sv
video_timing.sv
channel_mask.sv
com_accumulator.sv
com_divider.sv
overlay_mux.sv
color_tracker_top.sv
tb_clock_gen.sv
tb_color_tracker.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_color_tracker
RTL_TOP    := color_tracker_top
FILELIST   := list.f
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --timescale 1ns/1ps -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

# lint the design alone, then with the testbench on top
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only if the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST) --top-module $(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
